//--- common/mhq_pkg.sv
// Shared widths, LSU function codes and structs for the miss handling queue
// Lines are 16 bytes of 32-bit words, queue depth is limited to 8 by the tag field
package mhq_pkg;

    localparam int ADDR_WIDTH      = 32;
    localparam int DATA_WIDTH      = 32;
    localparam int LINE_WORDS      = 4;
    localparam int OFFSET_WIDTH    = 4;
    localparam int WORD_BYTES      = DATA_WIDTH / 8;
    localparam int LINE_BYTES      = LINE_WORDS * WORD_BYTES;
    localparam int BYTE_OFF_WIDTH  = $clog2(WORD_BYTES);
    localparam int WORD_IDX_WIDTH  = OFFSET_WIDTH - BYTE_OFF_WIDTH;
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;

    // Tag field wide enough for 8 entries, stages use the low bits
    localparam int MAX_TAG_WIDTH   = 3;

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        SB,
        SH,
        SW,
        FILL
    } lsu_func_t;

    typedef logic [LINE_ADDR_WIDTH-1:0]   line_addr_t;
    typedef logic [LINE_BYTES*8-1:0]      line_t;
    typedef logic [LINE_BYTES-1:0]        line_byte_sel_t;
    typedef logic [WORD_BYTES-1:0]        byte_sel_t;
    typedef logic [MAX_TAG_WIDTH-1:0]     tag_t;

    typedef struct packed {
        logic           valid;
        logic           locked;
        logic           dirty;
        line_addr_t     addr;
        line_t          data;
        line_byte_sel_t byte_updated;
    } mhq_entry_t;

    typedef struct packed {
        logic                  valid;
        logic                  dc_hit;
        logic [ADDR_WIDTH-1:0] addr;
        lsu_func_t             func;
        logic [DATA_WIDTH-1:0] data;
        logic                  we;
    } lookup_req_t;

    // Line address is carried so execute can fill in a new entry
    typedef struct packed {
        logic                    en;
        logic                    we;
        line_addr_t              addr;
        logic [OFFSET_WIDTH-1:0] offset;
        logic [DATA_WIDTH-1:0]   wr_data;
        byte_sel_t               byte_sel;
        logic                    match;
        tag_t                    tag;
    } lu_ex_t;

    typedef struct packed {
        logic       en;
        line_addr_t addr;
        tag_t       tag;
    } bypass_t;

    typedef struct packed {
        logic       valid;
        line_addr_t addr;
        line_t      line;
        logic       dirty;
    } fill_rsp_t;

endpackage

//--- mhq/mhq_lu.sv
// Lookup stage, matches a miss against the queue and registers the request for execute
// Store data is shifted to its byte lane here, requests that cannot join or allocate retry
`timescale 1ns/10ps

module mhq_lu #(
    parameter  int DEPTH     = 4,
    localparam int TAG_WIDTH = $clog2(DEPTH)
) (
    input  logic                                clk,
    input  logic                                n_rst,

    input  mhq_pkg::mhq_entry_t [DEPTH-1:0]     i_entries,
    input  logic [TAG_WIDTH-1:0]                i_tail,
    input  logic                                i_full,
    input  mhq_pkg::bypass_t                    i_bypass,

    input  mhq_pkg::lookup_req_t                i_lookup,

    output mhq_pkg::lu_ex_t                     o_lu,
    output logic                                o_retry
);

    logic                                   need;
    logic                                   accept;
    mhq_pkg::line_addr_t                    line_addr;
    logic [mhq_pkg::BYTE_OFF_WIDTH-1:0]     byte_off;
    logic [DEPTH-1:0]                       match_vec;
    logic [DEPTH-1:0]                       locked_vec;
    logic                                   entry_match;
    logic                                   locked_hit;
    logic                                   bypass_hit;
    logic [TAG_WIDTH-1:0]                   match_tag;
    logic [TAG_WIDTH-1:0]                   sel_tag;
    mhq_pkg::byte_sel_t                     width_sel;
    mhq_pkg::lu_ex_t                        lu_next;

    assign line_addr = i_lookup.addr[mhq_pkg::ADDR_WIDTH-1:mhq_pkg::OFFSET_WIDTH];
    assign byte_off  = i_lookup.addr[mhq_pkg::BYTE_OFF_WIDTH-1:0];

    // Only cache misses that are not refills concern the queue
    assign need = i_lookup.valid && !i_lookup.dc_hit && (i_lookup.func != mhq_pkg::FILL);

    // Compare against every valid entry
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            match_vec[i]  = i_entries[i].valid && (i_entries[i].addr == line_addr);
            locked_vec[i] = i_entries[i].locked;
        end
    end

    assign entry_match = |match_vec;
    assign locked_hit  = |(match_vec & locked_vec);
    assign bypass_hit  = i_bypass.en && (i_bypass.addr == line_addr);

    // At most one entry holds a given line, so any set bit gives the tag
    always_comb begin
        match_tag = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (match_vec[i]) begin
                match_tag = TAG_WIDTH'(i);
            end
        end
    end

    // Bypass first since the entry array does not show this cycle's write yet
    always_comb begin
        if (bypass_hit) begin
            sel_tag = i_bypass.tag[TAG_WIDTH-1:0];
        end else if (entry_match) begin
            sel_tag = match_tag;
        end else begin
            sel_tag = i_tail;
        end
    end

    // A full queue still takes requests that join an existing line
    assign accept = need && !locked_hit && (!i_full || entry_match || bypass_hit);

    always_comb begin
        case (i_lookup.func)
            mhq_pkg::SB: width_sel = mhq_pkg::byte_sel_t'(4'b0001);
            mhq_pkg::SH: width_sel = mhq_pkg::byte_sel_t'(4'b0011);
            mhq_pkg::SW: width_sel = mhq_pkg::byte_sel_t'(4'b1111);
            default:     width_sel = '0;
        endcase
    end

    always_comb begin
        lu_next          = '0;
        lu_next.en       = accept;
        lu_next.we       = i_lookup.we;
        lu_next.addr     = line_addr;
        lu_next.offset   = i_lookup.addr[mhq_pkg::OFFSET_WIDTH-1:0];
        lu_next.wr_data  = i_lookup.data << (8 * byte_off);
        lu_next.byte_sel = width_sel << byte_off;
        lu_next.match    = entry_match || bypass_hit;
        lu_next.tag      = mhq_pkg::tag_t'(sel_tag);
    end

    // Registered request for execute
    always_ff @(posedge clk) begin
        o_lu <= lu_next;
        if (!n_rst) begin
            o_lu.en <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_retry <= 1'b0;
        end else begin
            o_retry <= need && !accept;
        end
    end

endmodule

//--- mhq/mhq_ex.sv
// Execute stage, owns the entry array, allocates at tail and merges store bytes
// Depth must be a power of two, tail and full already include this cycle's allocation
`timescale 1ns/10ps

module mhq_ex #(
    parameter  int DEPTH     = 4,
    localparam int TAG_WIDTH = $clog2(DEPTH)
) (
    input  logic                                clk,
    input  logic                                n_rst,

    input  mhq_pkg::lu_ex_t                     i_lu,
    input  logic                                i_lock,
    input  logic                                i_free,

    output mhq_pkg::mhq_entry_t [DEPTH-1:0]     o_entries,
    output logic [TAG_WIDTH-1:0]                o_tail,
    output logic [TAG_WIDTH-1:0]                o_head,
    output logic                                o_full,
    output mhq_pkg::bypass_t                    o_bypass
);

    typedef logic [TAG_WIDTH:0] count_t;

    mhq_pkg::mhq_entry_t [DEPTH-1:0]        entries_q;
    mhq_pkg::mhq_entry_t                    upd;
    logic [TAG_WIDTH-1:0]                   head_q;
    logic [TAG_WIDTH-1:0]                   tail_q;
    count_t                                 count_q;
    count_t                                 count_next;
    logic [TAG_WIDTH-1:0]                   lu_tag;
    logic [mhq_pkg::WORD_IDX_WIDTH-1:0]     word;
    logic                                   alloc;

    assign lu_tag = i_lu.tag[TAG_WIDTH-1:0];
    assign word   = i_lu.offset[mhq_pkg::OFFSET_WIDTH-1:mhq_pkg::BYTE_OFF_WIDTH];
    assign alloc  = i_lu.en && !i_lu.match;

    // New state of the entry the request targets
    always_comb begin
        int idx;

        idx = 0;
        upd = entries_q[lu_tag];
        if (alloc) begin
            upd.valid        = 1'b1;
            upd.locked       = 1'b0;
            upd.dirty        = 1'b0;
            upd.addr         = i_lu.addr;
            upd.byte_updated = '0;
        end

        // Store bytes land in their word, loads only allocate or join
        if (i_lu.we) begin
            for (int b = 0; b < mhq_pkg::WORD_BYTES; b++) begin
                idx = int'(word) * mhq_pkg::WORD_BYTES + b;
                if (i_lu.byte_sel[b]) begin
                    upd.data[idx*8 +: 8]   = i_lu.wr_data[b*8 +: 8];
                    upd.byte_updated[idx]  = 1'b1;
                end
            end
            upd.dirty = 1'b1;
        end
    end

    // Lock and free act on the head after the merge so their fields win
    always_ff @(posedge clk) begin
        if (i_lu.en) begin
            entries_q[lu_tag] <= upd;
        end
        if (i_lock) begin
            entries_q[head_q].locked <= 1'b1;
        end
        if (i_free) begin
            entries_q[head_q].valid  <= 1'b0;
            entries_q[head_q].locked <= 1'b0;
        end
        if (!n_rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries_q[i].valid  <= 1'b0;
                entries_q[i].locked <= 1'b0;
            end
        end
    end

    assign count_next = count_q + count_t'(alloc) - count_t'(i_free);

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc) begin
                tail_q <= tail_q + TAG_WIDTH'(1);
            end
            if (i_free) begin
                head_q <= head_q + TAG_WIDTH'(1);
            end
            count_q <= count_next;
        end
    end

    assign o_entries = entries_q;
    assign o_head    = head_q;

    // Lookup sees where the next allocation goes after this cycle
    assign o_tail = alloc ? tail_q + TAG_WIDTH'(1) : tail_q;
    assign o_full = (count_next == count_t'(DEPTH));

    assign o_bypass.en   = i_lu.en;
    assign o_bypass.addr = i_lu.addr;
    assign o_bypass.tag  = i_lu.tag;

endmodule

//--- mhq/mhq_fill.sv
// Fill stage, reads the head entry's line over AXI4-Lite one word at a time
// Reads are issued one at a time, an error response still supplies its data
`timescale 1ns/10ps

module mhq_fill (
    input  logic                                clk,
    input  logic                                n_rst,

    input  mhq_pkg::mhq_entry_t                 i_head_entry,
    output logic                                o_lock,
    output logic                                o_free,

    // AXI4-Lite read channels
    output logic [mhq_pkg::ADDR_WIDTH-1:0]      o_araddr,
    output logic                                o_arvalid,
    input  logic                                i_arready,
    input  logic [mhq_pkg::DATA_WIDTH-1:0]      i_rdata,
    input  logic [1:0]                          i_rresp,
    input  logic                                i_rvalid,
    output logic                                o_rready,

    output mhq_pkg::fill_rsp_t                  o_fill
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } state_t;

    state_t                                 state_q;
    state_t                                 state_next;
    logic [mhq_pkg::WORD_IDX_WIDTH-1:0]     word_q;
    logic                                   beat;
    logic                                   last;
    mhq_pkg::line_t                         line_q;
    mhq_pkg::line_t                         mem_line;
    mhq_pkg::line_t                         merged;
    mhq_pkg::line_addr_t                    fill_addr_q;
    mhq_pkg::line_t                         fill_line_q;
    logic                                   fill_dirty_q;

    assign beat = (state_q == DATA) && i_rvalid;
    assign last = (word_q == mhq_pkg::WORD_IDX_WIDTH'(mhq_pkg::LINE_WORDS - 1));

    assign o_lock    = (state_q == IDLE) && i_head_entry.valid && !i_head_entry.locked;
    assign o_free    = beat && last;
    assign o_arvalid = (state_q == ADDR);
    assign o_rready  = (state_q == DATA);

    // Head is locked while reading, so its address holds steady
    assign o_araddr = {i_head_entry.addr, word_q, {mhq_pkg::BYTE_OFF_WIDTH{1'b0}}};

    always_comb begin
        state_next = state_q;
        case (state_q)
            IDLE: if (o_lock)    state_next = ADDR;
            ADDR: if (i_arready) state_next = DATA;
            DATA: if (i_rvalid)  state_next = last ? RESP : ADDR;
            RESP: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state_q <= IDLE;
            word_q  <= '0;
        end else begin
            state_q <= state_next;
            if (o_lock) begin
                word_q <= '0;
            end else if (beat) begin
                word_q <= word_q + mhq_pkg::WORD_IDX_WIDTH'(1);
            end
        end
    end

    // Memory line with the current beat dropped into its word
    always_comb begin
        mem_line = line_q;
        mem_line[int'(word_q)*mhq_pkg::DATA_WIDTH +: mhq_pkg::DATA_WIDTH] = i_rdata;
    end

    // Bytes written by stores override memory
    always_comb begin
        for (int b = 0; b < mhq_pkg::LINE_BYTES; b++) begin
            if (i_head_entry.byte_updated[b]) begin
                merged[b*8 +: 8] = i_head_entry.data[b*8 +: 8];
            end else begin
                merged[b*8 +: 8] = mem_line[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            line_q <= mem_line;
        end
        if (o_free) begin
            fill_addr_q  <= i_head_entry.addr;
            fill_line_q  <= merged;
            fill_dirty_q <= i_head_entry.dirty;
        end
    end

    // A bad response still completes the fill with the bytes as received
    assign o_fill.valid = (state_q == RESP);
    assign o_fill.addr  = fill_addr_q;
    assign o_fill.line  = fill_line_q;
    assign o_fill.dirty = fill_dirty_q;

endmodule

//--- mhq/mhq.sv
// Miss handling queue top, lookup, execute and fill stages with an AXI4-Lite read port
// DEPTH of 2, 4 or 8 entries, lookup and fill ports carry no handshake
`timescale 1ns/10ps

module mhq #(
    parameter int DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                n_rst,

    input  mhq_pkg::lookup_req_t                i_lookup,
    output logic                                o_retry,

    output logic [mhq_pkg::ADDR_WIDTH-1:0]      o_araddr,
    output logic                                o_arvalid,
    input  logic                                i_arready,
    input  logic [mhq_pkg::DATA_WIDTH-1:0]      i_rdata,
    input  logic [1:0]                          i_rresp,
    input  logic                                i_rvalid,
    output logic                                o_rready,

    output mhq_pkg::fill_rsp_t                  o_fill
);

    localparam int TAG_WIDTH = $clog2(DEPTH);

    mhq_pkg::mhq_entry_t [DEPTH-1:0]    entries;
    logic [TAG_WIDTH-1:0]               tail;
    logic [TAG_WIDTH-1:0]               head;
    logic                               full;
    mhq_pkg::bypass_t                   bypass;
    mhq_pkg::lu_ex_t                    lu;
    logic                               lock;
    logic                               free;

    mhq_lu #(.DEPTH(DEPTH)) u_lu (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_entries (entries),
        .i_tail    (tail),
        .i_full    (full),
        .i_bypass  (bypass),
        .i_lookup  (i_lookup),
        .o_lu      (lu),
        .o_retry   (o_retry)
    );

    mhq_ex #(.DEPTH(DEPTH)) u_ex (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_lu      (lu),
        .i_lock    (lock),
        .i_free    (free),
        .o_entries (entries),
        .o_tail    (tail),
        .o_head    (head),
        .o_full    (full),
        .o_bypass  (bypass)
    );

    mhq_fill u_fill (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_head_entry (entries[head]),
        .o_lock       (lock),
        .o_free       (free),
        .o_araddr     (o_araddr),
        .o_arvalid    (o_arvalid),
        .i_arready    (i_arready),
        .i_rdata      (i_rdata),
        .i_rresp      (i_rresp),
        .i_rvalid     (i_rvalid),
        .o_rready     (o_rready),
        .o_fill       (o_fill)
    );

endmodule

//--- tb/mhq_asserts.sv
// Port checks bound into mhq for AR address hold, one-cycle fill pulse and no retry on hits
// All checks are off while n_rst is low
`timescale 1ns/10ps

module mhq_asserts (
    input logic                             clk,
    input logic                             n_rst,
    input logic [mhq_pkg::ADDR_WIDTH-1:0]   i_araddr,
    input logic                             i_arvalid,
    input logic                             i_arready,
    input logic                             i_fill_valid,
    input logic                             i_retry,
    input logic                             i_lookup_valid,
    input logic                             i_lookup_hit
);

    int fail_count = 0;

    // Address must hold until the memory takes it
    ar_hold: assert property (@(posedge clk) disable iff (!n_rst)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
    else begin
        $error("ARADDR changed or ARVALID dropped before ARREADY");
        fail_count++;
    end

    fill_pulse: assert property (@(posedge clk) disable iff (!n_rst)
        i_fill_valid |=> !i_fill_valid)
    else begin
        $error("o_fill.valid stayed high for more than one cycle");
        fail_count++;
    end

    // A hit never concerns the queue, so its retry slot stays low
    hit_no_retry: assert property (@(posedge clk) disable iff (!n_rst)
        i_lookup_valid && i_lookup_hit |=> !i_retry)
    else begin
        $error("o_retry raised for a cache hit");
        fail_count++;
    end

endmodule

bind mhq mhq_asserts u_asserts (
    .clk            (clk),
    .n_rst          (n_rst),
    .i_araddr       (o_araddr),
    .i_arvalid      (o_arvalid),
    .i_arready      (i_arready),
    .i_fill_valid   (o_fill.valid),
    .i_retry        (o_retry),
    .i_lookup_valid (i_lookup.valid),
    .i_lookup_hit   (i_lookup.dc_hit)
);

//--- tb/mhq_tb.sv
// Directed testbench for the MHQ with an AXI4-Lite read memory model
// Memory word is address ^ 32'h5a5a_0000 after LFSR delays, ar_gate can hold ARREADY low
`timescale 1ns/10ps

module mhq_tb;

    localparam int DEPTH        = 4;
    localparam int FILL_TIMEOUT = 400;

    logic                               clk;
    logic                               n_rst;
    mhq_pkg::lookup_req_t               lookup;
    logic                               retry;
    logic [mhq_pkg::ADDR_WIDTH-1:0]     araddr;
    logic                               arvalid;
    logic                               arready = 1'b0;
    logic [mhq_pkg::DATA_WIDTH-1:0]     rdata = '0;
    logic [1:0]                         rresp = 2'b00;
    logic                               rvalid = 1'b0;
    logic                               rready;
    mhq_pkg::fill_rsp_t                 fill;

    // Memory model state
    logic                               ar_gate = 1'b1;
    logic                               ar_armed = 1'b0;
    int                                 ar_delay = 0;
    logic                               r_pending = 1'b0;
    int                                 r_delay = 0;
    logic [mhq_pkg::ADDR_WIDTH-1:0]     r_addr = '0;
    logic [31:0]                        lfsr_state = 32'h93a3;

    mhq_pkg::fill_rsp_t                 fills[$];
    int                                 retry_count = 0;
    int                                 errors = 0;
    int                                 tests_run = 0;
    int                                 tests_failed = 0;
    int                                 assert_fails;

    mhq #(.DEPTH(DEPTH)) DUT (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_lookup  (lookup),
        .o_retry   (retry),
        .o_araddr  (araddr),
        .o_arvalid (arvalid),
        .i_arready (arready),
        .i_rdata   (rdata),
        .i_rresp   (rresp),
        .i_rvalid  (rvalid),
        .o_rready  (rready),
        .o_fill    (fill)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Two fresh bits give 0 to 3 cycles
    function automatic int draw_delay();
        int d;
        d = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            d = d | (int'(lfsr_state[0]) << i);
        end
        return d;
    endfunction

    // AXI4-Lite read slave, one R beat per AR
    always @(posedge clk) begin
        if (!n_rst) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            rdata     <= '0;
            ar_armed  <= 1'b0;
            ar_delay  <= 0;
            r_pending <= 1'b0;
            r_delay   <= 0;
            r_addr    <= '0;
        end else begin
            if (arvalid && arready) begin
                arready   <= 1'b0;
                ar_armed  <= 1'b0;
                r_pending <= 1'b1;
                r_addr    <= araddr;
                r_delay   <= draw_delay();
            end else if (arvalid && !ar_armed) begin
                ar_armed <= 1'b1;
                ar_delay <= draw_delay();
            end else if (ar_armed && ar_gate && !arready) begin
                if (ar_delay == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_delay <= ar_delay - 1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (r_pending && !rvalid) begin
                if (r_delay == 0) begin
                    rvalid    <= 1'b1;
                    rdata     <= r_addr ^ 32'h5a5a_0000;
                    r_pending <= 1'b0;
                end else begin
                    r_delay <= r_delay - 1;
                end
            end
        end
    end

    // Outputs are recorded mid-cycle
    always @(negedge clk) begin
        if (fill.valid === 1'b1) begin
            fills.push_back(fill);
        end
        if (retry === 1'b1) begin
            retry_count++;
        end
    end

    function automatic mhq_pkg::line_t mem_line(input logic [31:0] addr);
        mhq_pkg::line_t line;
        logic [31:0]    word_addr;
        for (int w = 0; w < mhq_pkg::LINE_WORDS; w++) begin
            word_addr = {addr[31:4], 4'(w * 4)};
            line[w*32 +: 32] = word_addr ^ 32'h5a5a_0000;
        end
        return line;
    endfunction

    // The low data byte lands on the addressed byte
    function automatic mhq_pkg::line_t apply_store(input mhq_pkg::line_t line,
                                                   input logic [31:0] addr,
                                                   input mhq_pkg::lsu_func_t func,
                                                   input logic [31:0] data);
        mhq_pkg::line_t result;
        int             nbytes;
        int             base;
        result = line;
        nbytes = (func == mhq_pkg::SB) ? 1 : (func == mhq_pkg::SH) ? 2 : 4;
        base   = int'(addr[3:0]);
        for (int i = 0; i < nbytes; i++) begin
            result[(base+i)*8 +: 8] = data[i*8 +: 8];
        end
        return result;
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic send(input logic [31:0] addr, input mhq_pkg::lsu_func_t func,
                        input logic [31:0] data, input logic hit);
        mhq_pkg::lookup_req_t req;
        req        = '0;
        req.valid  = 1'b1;
        req.dc_hit = hit;
        req.addr   = addr;
        req.func   = func;
        req.data   = data;
        req.we     = (func == mhq_pkg::SB) || (func == mhq_pkg::SH) || (func == mhq_pkg::SW);
        @(posedge clk);
        lookup <= req;
    endtask

    task automatic end_requests();
        @(posedge clk);
        lookup <= '0;
    endtask

    task automatic wait_fills(input int count);
        int cycles;
        cycles = 0;
        while (fills.size() < count && cycles < FILL_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (fills.size() < count) begin
            $display("Timeout at %0t: only %0d of %0d fill responses arrived",
                     $time, fills.size(), count);
            errors++;
        end
    endtask

    task automatic wait_ar_request();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!arvalid && cycles < FILL_TIMEOUT);
        if (!arvalid) begin
            $display("Timeout at %0t: no AXI read address request appeared", $time);
            errors++;
        end
    endtask

    task automatic check_fill(input logic [31:0] addr, input mhq_pkg::line_t line,
                              input logic dirty);
        mhq_pkg::fill_rsp_t rsp;
        if (fills.size() == 0) begin
            $display("No fill response at %0t for address %h", $time, addr);
            errors++;
        end else begin
            rsp = fills.pop_front();
            check("o_fill.addr", 128'(rsp.addr), 128'(addr[31:4]));
            check("o_fill.line", rsp.line, line);
            check("o_fill.dirty", 128'(rsp.dirty), 128'(dirty));
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: FAIL", name);
            tests_failed++;
        end
    endtask

    task automatic load_miss();
        int errors_before;
        int retries_before;
        errors_before  = errors;
        retries_before = retry_count;
        send(32'h0000_1040, mhq_pkg::LW, '0, 1'b0);
        end_requests();
        wait_fills(1);
        check_fill(32'h0000_1040, mem_line(32'h0000_1040), 1'b0);
        check("o_retry count", 128'(retry_count - retries_before), 128'd0);
        report_test("load miss", errors_before);
    endtask

    // Back to back stores to one line join through the bypass
    task automatic store_merge();
        int             errors_before;
        mhq_pkg::line_t exp_line;
        errors_before = errors;
        exp_line = mem_line(32'h0000_2000);
        exp_line = apply_store(exp_line, 32'h0000_2004, mhq_pkg::SW, 32'hdead_beef);
        exp_line = apply_store(exp_line, 32'h0000_200a, mhq_pkg::SH, 32'h0000_1234);
        exp_line = apply_store(exp_line, 32'h0000_200f, mhq_pkg::SB, 32'h0000_0077);
        send(32'h0000_2004, mhq_pkg::SW, 32'hdead_beef, 1'b0);
        send(32'h0000_200a, mhq_pkg::SH, 32'h0000_1234, 1'b0);
        send(32'h0000_200f, mhq_pkg::SB, 32'h0000_0077, 1'b0);
        end_requests();
        wait_fills(1);
        check_fill(32'h0000_2000, exp_line, 1'b1);
        report_test("store merge", errors_before);
    endtask

    // The queue is held full, so a hit or refill taken for a miss would retry
    task automatic ignored_requests();
        int          errors_before;
        int          retries_before;
        logic [31:0] addr;
        errors_before  = errors;
        retries_before = retry_count;
        @(posedge clk);
        ar_gate <= 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            send(32'h0000_3100 + 32'(i * 16), mhq_pkg::LW, '0, 1'b0);
        end
        send(32'h0000_3000, mhq_pkg::LW, '0, 1'b1);
        send(32'h0000_3004, mhq_pkg::SW, 32'h0bad_f00d, 1'b1);
        send(32'h0000_3010, mhq_pkg::FILL, '0, 1'b0);
        end_requests();
        repeat (2) @(posedge clk);
        check("o_retry count", 128'(retry_count - retries_before), 128'd0);
        ar_gate <= 1'b1;
        wait_fills(DEPTH);
        for (int i = 0; i < DEPTH; i++) begin
            addr = 32'h0000_3100 + 32'(i * 16);
            check_fill(addr, mem_line(addr), 1'b0);
        end
        // Window long enough for any further fill to have finished
        repeat (40) @(posedge clk);
        check("fill count", 128'(fills.size()), 128'd0);
        report_test("hits and refills ignored", errors_before);
    endtask

    task automatic queue_full();
        int             errors_before;
        int             retries_before;
        mhq_pkg::line_t exp_line;
        errors_before  = errors;
        retries_before = retry_count;
        exp_line = apply_store(mem_line(32'h0000_4020), 32'h0000_4024, mhq_pkg::SW,
                               32'ha5a5_1234);
        @(posedge clk);
        ar_gate <= 1'b0;
        send(32'h0000_4000, mhq_pkg::LW, '0, 1'b0);
        send(32'h0000_4010, mhq_pkg::LW, '0, 1'b0);
        send(32'h0000_4020, mhq_pkg::LW, '0, 1'b0);
        send(32'h0000_4030, mhq_pkg::LW, '0, 1'b0);
        send(32'h0000_4040, mhq_pkg::LW, '0, 1'b0);
        send(32'h0000_4024, mhq_pkg::SW, 32'ha5a5_1234, 1'b0);
        end_requests();
        repeat (2) @(posedge clk);
        check("o_retry count", 128'(retry_count - retries_before), 128'd1);
        ar_gate <= 1'b1;
        wait_fills(4);
        check_fill(32'h0000_4000, mem_line(32'h0000_4000), 1'b0);
        check_fill(32'h0000_4010, mem_line(32'h0000_4010), 1'b0);
        check_fill(32'h0000_4020, exp_line, 1'b1);
        check_fill(32'h0000_4030, mem_line(32'h0000_4030), 1'b0);
        report_test("queue full", errors_before);
    endtask

    task automatic locked_entry();
        int errors_before;
        int retries_before;
        errors_before  = errors;
        retries_before = retry_count;
        @(posedge clk);
        ar_gate <= 1'b0;
        send(32'h0000_5000, mhq_pkg::LW, '0, 1'b0);
        end_requests();
        wait_ar_request();
        send(32'h0000_5008, mhq_pkg::SW, 32'h1111_2222, 1'b0);
        end_requests();
        repeat (2) @(posedge clk);
        check("o_retry count", 128'(retry_count - retries_before), 128'd1);
        ar_gate <= 1'b1;
        wait_fills(1);
        check_fill(32'h0000_5000, mem_line(32'h0000_5000), 1'b0);
        report_test("locked entry", errors_before);
    endtask

    initial begin
        n_rst  = 1'b0;
        lookup = '0;
        repeat (2) @(posedge clk);
        n_rst <= 1'b1;
        load_miss();
        store_merge();
        ignored_requests();
        queue_full();
        locked_entry();
        assert_fails = DUT.u_asserts.fail_count;
        $display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sim.f
common/mhq_pkg.sv
mhq/mhq_lu.sv
mhq/mhq_ex.sv
mhq/mhq_fill.sv
mhq/mhq.sv
tb/mhq_asserts.sv
tb/mhq_tb.sv

//--- Makefile
TOP := mhq_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -qx "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
